//--- hdl/serv_pkg.sv
package serv_pkg;

   // Datapath width
   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   // One position per serial bit
   typedef logic [4:0]      cnt_t;

   // ALU result select
   typedef logic [1:0]      alu_sel_t;

   localparam alu_sel_t alu_add = 2'd0;
   localparam alu_sel_t alu_and = 2'd1;
   localparam alu_sel_t alu_or  = 2'd2;
   localparam alu_sel_t alu_xor = 2'd3;

   // Core sequencing
   typedef enum logic [1:0] {
      st_fetch,
      st_rf_req,
      st_rf_wait,
      st_exec
   } state_t;

   localparam word_t reset_pc = '0;

   // Major opcodes
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;

   // funct3 codes of the supported ALU operations
   localparam logic [2:0] f3_add = 3'b000;
   localparam logic [2:0] f3_xor = 3'b100;
   localparam logic [2:0] f3_or  = 3'b110;
   localparam logic [2:0] f3_and = 3'b111;

endpackage

//--- hdl/core_state.sv
module core_state (
   input  logic clk,
   input  logic i_arst_n,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   input  logic i_cnt_done,
   output logic o_ibus_cyc,
   output logic o_fetch_ack,
   output logic o_rf_rreq,
   output logic o_cnt_en
);

   serv_pkg::state_t state_q;
   serv_pkg::state_t state_d;
   logic             cyc_q;

   // Ack only counts while a fetch is on the bus
   assign o_fetch_ack = cyc_q & i_ibus_ack & (state_q == serv_pkg::st_fetch);
   assign o_ibus_cyc  = cyc_q;
   assign o_rf_rreq   = (state_q == serv_pkg::st_rf_req);
   assign o_cnt_en    = (state_q == serv_pkg::st_exec);

   always_comb begin
      state_d = state_q;
      case (state_q)
         serv_pkg::st_fetch: begin
            if (o_fetch_ack) begin
               state_d = serv_pkg::st_rf_req;
            end
         end
         serv_pkg::st_rf_req: begin
            state_d = serv_pkg::st_rf_wait;
         end
         serv_pkg::st_rf_wait: begin
            if (i_rf_ready) begin
               state_d = serv_pkg::st_exec;
            end
         end
         default: begin
            if (i_cnt_done) begin
               state_d = serv_pkg::st_fetch;
            end
         end
      endcase
   end

   // Bus cycle opens together with the fetch state
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= serv_pkg::st_fetch;
         cyc_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         cyc_q   <= (state_d == serv_pkg::st_fetch);
      end
   end

   a_rreq_pulse : assert property (@(posedge clk) disable iff (!i_arst_n)
      o_rf_rreq |=> !o_rf_rreq);

   // Fetch and execute never overlap
   a_no_fetch_in_exec : assert property (@(posedge clk) disable iff (!i_arst_n)
      o_ibus_cyc |-> !o_cnt_en);

endmodule

//--- hdl/bit_counter.sv
module bit_counter (
   input  logic clk,
   input  logic i_arst_n,
   input  logic i_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done
);

   serv_pkg::cnt_t cnt_q;

   // Wraps to zero after bit 31
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cnt_q <= '0;
      end else if (i_cnt_en) begin
         cnt_q <= cnt_q + 5'd1;
      end
   end

   assign o_cnt0     = (cnt_q == 5'd0);
   assign o_cnt_done = i_cnt_en & (cnt_q == 5'd31);

endmodule

//--- hdl/instr_decode.sv
module instr_decode (
   input  logic                clk,
   input  logic                i_arst_n,
   input  logic                i_fetch_ack,
   input  serv_pkg::word_t     i_ibus_rdt,
   input  logic                i_cnt_en,
   output serv_pkg::reg_addr_t o_rs1_addr,
   output serv_pkg::reg_addr_t o_rs2_addr,
   output serv_pkg::reg_addr_t o_rd_addr,
   output serv_pkg::alu_sel_t  o_alu_sel,
   output logic                o_alu_sub,
   output logic                o_op_b_imm,
   output logic                o_lui,
   output logic                o_rd_wen,
   output logic                o_imm
);

   logic [6:0]         opcode;
   logic [2:0]         funct3;
   logic               is_op;
   logic               is_op_imm;
   logic               is_lui;
   logic               f3_ok;
   logic               supported;
   serv_pkg::alu_sel_t sel_d;
   serv_pkg::word_t    imm_i;
   serv_pkg::word_t    imm_u;
   serv_pkg::word_t    instr_q;
   serv_pkg::word_t    imm_q;

   assign opcode    = i_ibus_rdt[6:0];
   assign funct3    = i_ibus_rdt[14:12];
   assign is_op     = (opcode == serv_pkg::opc_op);
   assign is_op_imm = (opcode == serv_pkg::opc_op_imm);
   assign is_lui    = (opcode == serv_pkg::opc_lui);

   assign f3_ok = (funct3 == serv_pkg::f3_add) | (funct3 == serv_pkg::f3_xor) |
                  (funct3 == serv_pkg::f3_or) | (funct3 == serv_pkg::f3_and);

   // Anything else runs as a no-op
   assign supported = is_lui | ((is_op | is_op_imm) & f3_ok);

   always_comb begin
      case (funct3)
         serv_pkg::f3_xor: sel_d = serv_pkg::alu_xor;
         serv_pkg::f3_or:  sel_d = serv_pkg::alu_or;
         serv_pkg::f3_and: sel_d = serv_pkg::alu_and;
         default:          sel_d = serv_pkg::alu_add;
      endcase
   end

   assign imm_i = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
   assign imm_u = {i_ibus_rdt[31:12], 12'b0};

   // Immediate goes out LSB first at one bit per execute cycle
   always_ff @(posedge clk) begin
      if (i_fetch_ack) begin
         instr_q <= i_ibus_rdt;
         imm_q   <= is_lui ? imm_u : imm_i;
      end else if (i_cnt_en) begin
         imm_q <= {1'b0, imm_q[serv_pkg::xlen-1:1]};
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_alu_sel  <= serv_pkg::alu_add;
         o_alu_sub  <= 1'b0;
         o_op_b_imm <= 1'b0;
         o_lui      <= 1'b0;
         o_rd_wen   <= 1'b0;
      end else if (i_fetch_ack) begin
         o_alu_sel  <= sel_d;
         // SUB only exists in register form
         o_alu_sub  <= is_op & (funct3 == serv_pkg::f3_add) & i_ibus_rdt[30];
         o_op_b_imm <= is_op_imm;
         o_lui      <= is_lui;
         o_rd_wen   <= supported & (i_ibus_rdt[11:7] != 5'd0);
      end
   end

   assign o_rs1_addr = instr_q[19:15];
   assign o_rs2_addr = instr_q[24:20];
   assign o_rd_addr  = instr_q[11:7];
   assign o_imm      = imm_q[0];

endmodule

//--- hdl/serial_alu.sv
module serial_alu (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic               i_cnt_en,
   input  logic               i_cnt0,
   input  logic               i_rs1,
   input  logic               i_rs2,
   input  logic               i_imm,
   input  logic               i_op_b_imm,
   input  logic               i_alu_sub,
   input  serv_pkg::alu_sel_t i_alu_sel,
   input  logic               i_lui,
   output logic               o_rd
);

   logic op_b;
   logic add_b;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic result;

   assign op_b  = i_op_b_imm ? i_imm : i_rs2;
   // The +1 of a subtract enters as carry at bit 0
   assign add_b    = op_b ^ i_alu_sub;
   assign carry_in = i_cnt0 ? i_alu_sub : carry_q;
   assign sum      = i_rs1 ^ add_b ^ carry_in;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= (i_rs1 & add_b) | (carry_in & (i_rs1 ^ add_b));
      end
   end

   always_comb begin
      case (i_alu_sel)
         serv_pkg::alu_and: result = i_rs1 & op_b;
         serv_pkg::alu_or:  result = i_rs1 | op_b;
         serv_pkg::alu_xor: result = i_rs1 ^ op_b;
         default:           result = sum;
      endcase
   end

   assign o_rd = i_lui ? i_imm : result;

endmodule

//--- hdl/program_counter.sv
module program_counter (
   input  logic            clk,
   input  logic            i_arst_n,
   input  logic            i_cnt_en,
   input  logic            i_cnt0,
   output serv_pkg::word_t o_pc
);

   logic pos1_q;
   logic pos2_q;
   logic carry_in;
   logic carry_q;
   logic sum;

   // pos2_q marks bit 2 as the addend of +4
   assign carry_in = i_cnt0 ? 1'b0 : carry_q;
   assign sum      = o_pc[0] ^ pos2_q ^ carry_in;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_pc    <= serv_pkg::reset_pc;
         pos1_q  <= 1'b0;
         pos2_q  <= 1'b0;
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         o_pc    <= {sum, o_pc[serv_pkg::xlen-1:1]};
         pos1_q  <= i_cnt0;
         pos2_q  <= pos1_q;
         carry_q <= (o_pc[0] & pos2_q) | (carry_in & (o_pc[0] ^ pos2_q));
      end
   end

   // Low bits only move while rotating
   a_pc_aligned : assert property (@(posedge clk) disable iff (!i_arst_n)
      !i_cnt_en |-> (o_pc[1:0] == 2'b00));

endmodule

//--- hdl/serial_core.sv
module serial_core (
   input  logic                clk,
   input  logic                i_arst_n,
   input  serv_pkg::word_t     i_ibus_rdt,
   input  logic                i_ibus_ack,
   input  logic                i_rf_ready,
   input  logic                i_rdata0,
   input  logic                i_rdata1,
   output serv_pkg::word_t     o_ibus_adr,
   output logic                o_ibus_cyc,
   output logic                o_rf_rreq,
   output serv_pkg::reg_addr_t o_rreg0,
   output serv_pkg::reg_addr_t o_rreg1,
   output serv_pkg::reg_addr_t o_wreg0,
   output logic                o_wen0,
   output logic                o_wdata0
);

   logic               cnt_en;
   logic               cnt0;
   logic               cnt_done;
   logic               fetch_ack;
   serv_pkg::alu_sel_t alu_sel;
   logic               alu_sub;
   logic               op_b_imm;
   logic               lui;
   logic               rd_wen;
   logic               imm;
   logic               rd_bit;

   core_state state_i (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_ibus_ack  (i_ibus_ack),
      .i_rf_ready  (i_rf_ready),
      .i_cnt_done  (cnt_done),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_fetch_ack (fetch_ack),
      .o_rf_rreq   (o_rf_rreq),
      .o_cnt_en    (cnt_en)
   );

   bit_counter cnt_i (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (cnt_done)
   );

   instr_decode decode_i (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_fetch_ack (fetch_ack),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_cnt_en    (cnt_en),
      .o_rs1_addr  (o_rreg0),
      .o_rs2_addr  (o_rreg1),
      .o_rd_addr   (o_wreg0),
      .o_alu_sel   (alu_sel),
      .o_alu_sub   (alu_sub),
      .o_op_b_imm  (op_b_imm),
      .o_lui       (lui),
      .o_rd_wen    (rd_wen),
      .o_imm       (imm)
   );

   serial_alu alu_i (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_rs1      (i_rdata0),
      .i_rs2      (i_rdata1),
      .i_imm      (imm),
      .i_op_b_imm (op_b_imm),
      .i_alu_sub  (alu_sub),
      .i_alu_sel  (alu_sel),
      .i_lui      (lui),
      .o_rd       (rd_bit)
   );

   program_counter pc_i (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_cnt_en (cnt_en),
      .i_cnt0   (cnt0),
      .o_pc     (o_ibus_adr)
   );

   assign o_wen0   = cnt_en & rd_wen;
   assign o_wdata0 = rd_bit;

   // x0 stays zero
   a_no_x0_write : assert property (@(posedge clk) disable iff (!i_arst_n)
      o_wen0 |-> (o_wreg0 != 5'd0));

endmodule

//--- test/tb_serial_core.sv
module tb_serial_core;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int fetch_timeout = 50;
   localparam int rreq_timeout  = 10;
   // A store, outside the supported set
   localparam logic [6:0] opc_store = 7'b0100011;

   logic                clk;
   logic                i_arst_n;
   serv_pkg::word_t     i_ibus_rdt;
   logic                i_ibus_ack;
   logic                i_rf_ready;
   logic                i_rdata0;
   logic                i_rdata1;
   serv_pkg::word_t     o_ibus_adr;
   logic                o_ibus_cyc;
   logic                o_rf_rreq;
   serv_pkg::reg_addr_t o_rreg0;
   serv_pkg::reg_addr_t o_rreg1;
   serv_pkg::reg_addr_t o_wreg0;
   logic                o_wen0;
   logic                o_wdata0;

   serv_pkg::word_t regs [0:31];
   serv_pkg::word_t prog [0:255];
   serv_pkg::word_t exp_pc;

   serial_core dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input serv_pkg::word_t exp,
                             input serv_pkg::word_t act);
      if (exp !== act) begin
         abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_addr(input string name, input serv_pkg::reg_addr_t exp,
                             input serv_pkg::reg_addr_t act);
      if (exp !== act) begin
         abort_run($sformatf("Fail %s: expected x%0d, actual x%0d", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic next_cycle;
      @(posedge clk);
      #2;
   endtask

   function automatic serv_pkg::word_t reg_val(input serv_pkg::reg_addr_t a);
      return (a == 5'd0) ? '0 : regs[a];
   endfunction

   function automatic serv_pkg::word_t enc_r(input logic [6:0] f7,
                                             input serv_pkg::reg_addr_t rs2,
                                             input serv_pkg::reg_addr_t rs1,
                                             input logic [2:0] f3,
                                             input serv_pkg::reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, serv_pkg::opc_op};
   endfunction

   function automatic serv_pkg::word_t enc_i(input logic [11:0] imm,
                                             input serv_pkg::reg_addr_t rs1,
                                             input logic [2:0] f3,
                                             input serv_pkg::reg_addr_t rd,
                                             input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic serv_pkg::word_t enc_u(input logic [19:0] imm,
                                             input serv_pkg::reg_addr_t rd);
      return {imm, rd, serv_pkg::opc_lui};
   endfunction

   task automatic wait_fetch(input string name);
      int n;
      n = 0;
      while (!o_ibus_cyc) begin
         if (n == fetch_timeout) begin
            abort_run($sformatf("%s: timed out waiting for an instruction fetch", name));
         end
         n++;
         next_cycle();
      end
   endtask

   // Runs one instruction from the fetch in progress to the next fetch
   task automatic issue_instr(input string name, input serv_pkg::word_t instr,
                              output int wen_cycles);
      int              ack_dly;
      int              rdy_dly;
      int              n;
      serv_pkg::word_t rs1_val;
      serv_pkg::word_t rs2_val;
      prog[exp_pc[9:2]] = instr;
      check_word(name, exp_pc, o_ibus_adr);
      ack_dly = $urandom % 4;
      repeat (ack_dly) begin
         check_bit(name, 1'b1, o_ibus_cyc);
         check_word(name, exp_pc, o_ibus_adr);
         next_cycle();
      end
      i_ibus_rdt = prog[o_ibus_adr[9:2]];
      i_ibus_ack = 1'b1;
      next_cycle();
      i_ibus_ack = 1'b0;
      i_ibus_rdt = $urandom;
      n = 0;
      while (!o_rf_rreq) begin
         if (n == rreq_timeout) begin
            abort_run($sformatf("%s: timed out waiting for a register file request", name));
         end
         n++;
         next_cycle();
      end
      check_addr(name, instr[19:15], o_rreg0);
      check_addr(name, instr[24:20], o_rreg1);
      rs1_val = reg_val(instr[19:15]);
      rs2_val = reg_val(instr[24:20]);
      rdy_dly = 1 + $urandom % 4;
      repeat (rdy_dly) begin
         check_bit(name, 1'b0, o_wen0);
         next_cycle();
      end
      i_rf_ready = 1'b1;
      next_cycle();
      i_rf_ready = 1'b0;
      wen_cycles = 0;
      for (int k = 0; k < 32; k++) begin
         i_rdata0 = rs1_val[k];
         i_rdata1 = rs2_val[k];
         #1;
         if (o_wen0) begin
            wen_cycles++;
            check_addr(name, instr[11:7], o_wreg0);
            regs[o_wreg0][k] = o_wdata0;
         end
         next_cycle();
      end
      i_rdata0 = 1'b0;
      i_rdata1 = 1'b0;
      wait_fetch(name);
      check_word(name, exp_pc + 32'd4, o_ibus_adr);
      exp_pc = exp_pc + 32'd4;
   endtask

   task automatic test_reset;
      repeat (4) begin
         next_cycle();
         check_bit("reset cyc", 1'b0, o_ibus_cyc);
         check_bit("reset rreq", 1'b0, o_rf_rreq);
         check_bit("reset wen", 1'b0, o_wen0);
      end
      i_arst_n = 1'b1;
      wait_fetch("reset");
      check_word("reset", serv_pkg::reset_pc, o_ibus_adr);
      exp_pc = serv_pkg::reset_pc;
   endtask

   task automatic test_add_sub;
      serv_pkg::word_t a;
      serv_pkg::word_t b;
      logic [11:0]     imm;
      int              wen;
      for (int i = 0; i < 4; i++) begin
         a       = $urandom;
         b       = $urandom;
         imm     = 12'($urandom);
         // Every other immediate negative
         imm[11] = i[0];
         regs[1] = a;
         regs[2] = b;
         issue_instr("add", enc_r(7'h00, 5'd2, 5'd1, serv_pkg::f3_add, 5'd3), wen);
         check_word("add", a + b, regs[3]);
         check_bit("add wen", 1'b1, wen == 32);
         issue_instr("sub", enc_r(7'h20, 5'd2, 5'd1, serv_pkg::f3_add, 5'd4), wen);
         check_word("sub", a - b, regs[4]);
         issue_instr("addi", enc_i(imm, 5'd1, serv_pkg::f3_add, 5'd5,
                                   serv_pkg::opc_op_imm), wen);
         check_word("addi", a + {{20{imm[11]}}, imm}, regs[5]);
      end
   endtask

   task automatic test_logic;
      serv_pkg::word_t a;
      serv_pkg::word_t b;
      serv_pkg::word_t sx;
      logic [11:0]     imm;
      int              wen;
      for (int i = 0; i < 3; i++) begin
         a       = $urandom;
         b       = $urandom;
         imm     = 12'($urandom);
         sx      = {{20{imm[11]}}, imm};
         regs[1] = a;
         regs[2] = b;
         issue_instr("and", enc_r(7'h00, 5'd2, 5'd1, serv_pkg::f3_and, 5'd6), wen);
         check_word("and", a & b, regs[6]);
         issue_instr("or", enc_r(7'h00, 5'd2, 5'd1, serv_pkg::f3_or, 5'd7), wen);
         check_word("or", a | b, regs[7]);
         issue_instr("xor", enc_r(7'h00, 5'd2, 5'd1, serv_pkg::f3_xor, 5'd8), wen);
         check_word("xor", a ^ b, regs[8]);
         issue_instr("andi", enc_i(imm, 5'd1, serv_pkg::f3_and, 5'd9,
                                   serv_pkg::opc_op_imm), wen);
         check_word("andi", a & sx, regs[9]);
         issue_instr("ori", enc_i(imm, 5'd1, serv_pkg::f3_or, 5'd10,
                                  serv_pkg::opc_op_imm), wen);
         check_word("ori", a | sx, regs[10]);
         issue_instr("xori", enc_i(imm, 5'd1, serv_pkg::f3_xor, 5'd11,
                                   serv_pkg::opc_op_imm), wen);
         check_word("xori", a ^ sx, regs[11]);
      end
   endtask

   task automatic test_lui;
      logic [19:0] imm;
      int          wen;
      for (int i = 0; i < 3; i++) begin
         imm      = 20'($urandom);
         regs[12] = $urandom;
         issue_instr("lui", enc_u(imm, 5'd12), wen);
         check_word("lui", {imm, 12'h000}, regs[12]);
      end
   endtask

   task automatic test_no_write;
      serv_pkg::word_t saved [0:31];
      int              wen;
      for (int i = 0; i < 2; i++) begin
         regs[1] = $urandom;
         regs[2] = $urandom;
         saved   = regs;
         issue_instr("add x0", enc_r(7'h00, 5'd2, 5'd1, serv_pkg::f3_add, 5'd0), wen);
         check_bit("add x0 wen", 1'b0, wen != 0);
         // funct3 of a shift
         issue_instr("sll", enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd13), wen);
         check_bit("sll wen", 1'b0, wen != 0);
         issue_instr("store", enc_i(12'h010, 5'd1, 3'b010, 5'd14, opc_store), wen);
         check_bit("store wen", 1'b0, wen != 0);
         for (int r = 0; r < 32; r++) begin
            check_word("no write", saved[r], regs[r]);
         end
      end
   endtask

   initial begin
      i_arst_n   = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0   = 1'b0;
      i_rdata1   = 1'b0;
      regs       = '{default: '0};
      exp_pc     = serv_pkg::reset_pc;
      void'($urandom(89));
      test_reset();
      test_add_sub();
      test_logic();
      test_lui();
      test_no_write();
      $display("sim passed");
      $finish;
   end

endmodule

//--- serial_core.f
hdl/serv_pkg.sv
hdl/core_state.sv
hdl/bit_counter.sv
hdl/instr_decode.sv
hdl/serial_alu.sv
hdl/program_counter.sv
hdl/serial_core.sv
test/tb_serial_core.sv

//--- Makefile
# Verilator build and run for the serial core testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_core
FILELIST  ?= serial_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
